//--- source/isaPkg.sv
package isaPkg;

    // First-level decode, top two instruction bits
    typedef enum logic [1:0] {
        groupImm    = 2'd0,
        groupReg    = 2'd1,
        groupMem    = 2'd2,   // No load/store here, treated as a no-op
        groupBranch = 2'd3
    } groupT;

    // Move table of the immediate group
    localparam logic [2:0] fnMov  = 3'd0;
    localparam logic [2:0] fnMovt = 3'd1;
    localparam logic [2:0] fnClr  = 3'd2;
    localparam logic [2:0] fnSet  = 3'd3;
    localparam logic [2:0] fnLsl  = 3'd4;
    localparam logic [2:0] fnLsr  = 3'd5;

    // Second-level table, bit 3 marks the flag-setting form
    localparam logic [3:0] secAdd  = 4'd1;
    localparam logic [3:0] secSub  = 4'd2;
    localparam logic [3:0] secAnd  = 4'd3;
    localparam logic [3:0] secOr   = 4'd4;
    localparam logic [3:0] secXor  = 4'd5;
    localparam logic [3:0] secAdds = 4'd9;
    localparam logic [3:0] secSubs = 4'd10;
    localparam logic [3:0] secAnds = 4'd11;
    localparam logic [3:0] secOrs  = 4'd12;
    localparam logic [3:0] secXors = 4'd13;

    // Branch conditions
    localparam logic [3:0] brEq = 4'd0;
    localparam logic [3:0] brNe = 4'd1;
    localparam logic [3:0] brMi = 4'd4;

    typedef enum logic [3:0] {
        opNone,
        opAdd,
        opSub,
        opAnd,
        opOr,
        opXor,
        opMov,
        opMovt,
        opClr,
        opSet,
        opLsl,
        opLsr
    } aluOpT;

    typedef enum logic [1:0] {condNone, condEq, condNe, condMi} branchCondT;

endpackage

//--- source/datapathPkg.sv
package datapathPkg;

    localparam int dataWidth    = 32;
    localparam int regAddrWidth = 4;
    localparam int immWidth     = 16;

    // One data word of the register file
    typedef logic [dataWidth-1:0] wordT;

    // Register number, 16 registers
    typedef logic [regAddrWidth-1:0] regAddrT;

    // Immediate as it arrives from the instruction
    typedef logic [immWidth-1:0] immT;

    // Condition flags, N in the top bit
    typedef logic [3:0] flagsT;

    localparam int flagN = 3;
    localparam int flagZ = 2;
    localparam int flagC = 1;
    localparam int flagV = 0;

endpackage

//--- source/opBus.sv
`timescale 1ns/100ps

interface opBus
    import isaPkg::*, datapathPkg::*;
();
    aluOpT      aluOp;
    logic       useImm;       // Second operand is immExt, not the second register
    wordT       immExt;       // Sign-extended immediate
    immT        immRaw;       // For MOVT and the shift amount
    logic       writesReg;
    logic       setsFlags;
    branchCondT branchCond;

    modport decodeSide (
        output aluOp,
        output useImm,
        output immExt,
        output immRaw,
        output writesReg,
        output setsFlags,
        output branchCond
    );

    modport executeSide (input aluOp, input useImm, input immExt, input immRaw);

    modport resultSide (input aluOp, input writesReg, input setsFlags, input branchCond);

endinterface

//--- source/instrDecode.sv
`timescale 1ns/100ps

module instrDecode
    import isaPkg::*, datapathPkg::*;
(
    input  groupT      firstLevelDecode,
    input  logic       specialEncoding,
    input  logic [3:0] secondLevelDecode,
    input  logic [2:0] aluFunctions,
    input  logic [3:0] branchInstruction,
    input  immT        imm,
    input  regAddrT    destReg,
    input  regAddrT    sourceFirstReg,
    input  regAddrT    sourceSecReg,
    output regAddrT    readRegDest,
    output regAddrT    readRegFirst,
    output regAddrT    readRegSec,
    opBus.decodeSide   op
);
    aluOpT      secOp;
    logic       secSets;
    aluOpT      movOp;
    aluOpT      decodedOp;
    logic       setsFlagsDec;
    logic       useImmDec;
    branchCondT cond;
    logic       writes;
    logic       readsFirst;
    logic       readsSec;

    // Second-level table, shared by immediate and register groups
    always_comb begin
        secOp   = opNone;
        secSets = 1'b0;
        case (secondLevelDecode)
            secAdd:  secOp = opAdd;
            secSub:  secOp = opSub;
            secAnd:  secOp = opAnd;
            secOr:   secOp = opOr;
            secXor:  secOp = opXor;
            secAdds: secOp = opAdd;
            secSubs: secOp = opSub;
            secAnds: secOp = opAnd;
            secOrs:  secOp = opOr;
            secXors: secOp = opXor;
            default: secOp = opNone;
        endcase
        secSets = secondLevelDecode[3] && (secOp != opNone);
    end

    always_comb begin
        case (aluFunctions)
            fnMov:   movOp = opMov;
            fnMovt:  movOp = opMovt;
            fnClr:   movOp = opClr;
            fnSet:   movOp = opSet;
            fnLsl:   movOp = opLsl;
            fnLsr:   movOp = opLsr;
            default: movOp = opNone;   // MOVF and spare codes
        endcase
    end

    always_comb begin
        decodedOp    = opNone;
        setsFlagsDec = 1'b0;
        useImmDec    = 1'b0;
        cond         = condNone;
        case (firstLevelDecode)
            groupImm: begin
                if (specialEncoding) begin
                    decodedOp    = secOp;
                    setsFlagsDec = secSets;
                    useImmDec    = 1'b1;
                end else begin
                    decodedOp = movOp;
                end
            end
            groupReg: begin
                decodedOp    = secOp;
                setsFlagsDec = secSets;
            end
            groupBranch: begin
                case (branchInstruction)
                    brEq:    cond = condEq;
                    brNe:    cond = condNe;
                    brMi:    cond = condMi;
                    default: cond = condNone;
                endcase
            end
            default: decodedOp = opNone;   // Memory group
        endcase
    end

    assign writes     = (decodedOp != opNone);
    assign readsFirst = writes && !(decodedOp inside {opMov, opMovt, opClr, opSet});
    assign readsSec   = writes && (firstLevelDecode == groupReg);

    // Dest address doubles as the write address of the register file
    assign readRegDest  = writes ? destReg : '0;
    assign readRegFirst = readsFirst ? sourceFirstReg : '0;
    assign readRegSec   = readsSec ? sourceSecReg : '0;

    assign op.aluOp      = decodedOp;
    assign op.useImm     = useImmDec;
    assign op.immExt     = {{(dataWidth - immWidth){imm[immWidth-1]}}, imm};
    assign op.immRaw     = imm;
    assign op.writesReg  = writes;
    assign op.setsFlags  = setsFlagsDec;
    assign op.branchCond = cond;

endmodule

//--- source/aluExecute.sv
`timescale 1ns/100ps

module aluExecute
    import isaPkg::*, datapathPkg::*;
(
    opBus.executeSide op,
    input  wordT      readDataDest,
    input  wordT      readDataFirst,
    input  wordT      readDataSec,
    output wordT      result,
    output flagsT     flagsNew
);
    wordT               operandB;
    logic [dataWidth:0] sum;
    logic [dataWidth:0] diff;
    wordT               shiftLeft;
    wordT               shiftRight;
    logic               signA;
    logic               signB;
    logic               signR;

    assign operandB = op.useImm ? op.immExt : readDataSec;

    // 33-bit forms keep the carry and borrow
    assign sum  = {1'b0, readDataFirst} + {1'b0, operandB};
    assign diff = {1'b0, readDataFirst} - {1'b0, operandB};

    // Amounts of 32 and more shift every bit out
    assign shiftLeft  = readDataFirst << op.immRaw;
    assign shiftRight = readDataFirst >> op.immRaw;

    always_comb begin
        case (op.aluOp)
            opAdd:   result = sum[dataWidth-1:0];
            opSub:   result = diff[dataWidth-1:0];
            opAnd:   result = readDataFirst & operandB;
            opOr:    result = readDataFirst | operandB;
            opXor:   result = readDataFirst ^ operandB;
            opMov:   result = op.immExt;
            opMovt:  result = {op.immRaw, readDataDest[immWidth-1:0]};  // Keep old low half
            opClr:   result = '0;
            opSet:   result = '1;
            opLsl:   result = shiftLeft;
            opLsr:   result = shiftRight;
            default: result = '0;
        endcase
    end

    assign signA = readDataFirst[dataWidth-1];
    assign signB = operandB[dataWidth-1];
    assign signR = result[dataWidth-1];

    always_comb begin
        flagsNew[flagN] = signR;
        flagsNew[flagZ] = (result == '0);
        flagsNew[flagC] = 1'b0;   // Only meaningful for add and subtract
        flagsNew[flagV] = 1'b0;
        case (op.aluOp)
            opAdd: begin
                flagsNew[flagC] = sum[dataWidth];
                // Same-sign operands with a sign flip in the result
                flagsNew[flagV] = ~(signA ^ signB) & (signA ^ signR);
            end
            opSub: begin
                flagsNew[flagC] = ~diff[dataWidth];   // Carry is not-borrow
                flagsNew[flagV] = (signA ^ signB) & (signA ^ signR);
            end
            default: begin
                flagsNew[flagC] = 1'b0;
                flagsNew[flagV] = 1'b0;
            end
        endcase
    end

endmodule

//--- source/writebackFlags.sv
`timescale 1ns/100ps

module writebackFlags
    import isaPkg::*, datapathPkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  wordT      result,
    input  flagsT     flagsNew,
    opBus.resultSide  op,
    output wordT      writeData,
    output logic      writeToReg,
    output logic      branchTaken,
    output flagsT     flags
);
    flagsT flagsNext;
    logic  isArith;

    assign isArith = (op.aluOp == opAdd) || (op.aluOp == opSub);

    // Logical ops leave C and V as they were
    always_comb begin
        flagsNext = flags;
        if (op.setsFlags) begin
            if (isArith) begin
                flagsNext = flagsNew;
            end else begin
                flagsNext[flagN] = flagsNew[flagN];
                flagsNext[flagZ] = flagsNew[flagZ];
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            flags <= '0;
        end else begin
            flags <= flagsNext;
        end
    end

    // Branches look at the held flags, not this cycle's update
    always_comb begin
        case (op.branchCond)
            condEq:  branchTaken = flags[flagZ];
            condNe:  branchTaken = ~flags[flagZ];
            condMi:  branchTaken = flags[flagN];
            default: branchTaken = 1'b0;
        endcase
    end

    assign writeToReg = op.writesReg;
    assign writeData  = op.writesReg ? result : '0;   // Quiet bus when nothing is written

endmodule

//--- source/executeStage.sv
`timescale 1ns/100ps

module executeStage
    import datapathPkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  isaPkg::groupT firstLevelDecode,
    input  logic          specialEncoding,
    input  logic [3:0]    secondLevelDecode,
    input  logic [2:0]    aluFunctions,
    input  logic [3:0]    branchInstruction,
    input  immT           imm,
    input  regAddrT       destReg,
    input  regAddrT       sourceFirstReg,
    input  regAddrT       sourceSecReg,
    input  wordT          readDataDest,
    input  wordT          readDataFirst,
    input  wordT          readDataSec,
    output regAddrT       readRegDest,
    output regAddrT       readRegFirst,
    output regAddrT       readRegSec,
    output wordT          writeData,
    output logic          writeToReg,
    output logic          branchTaken,
    output flagsT         flags
);
    wordT  result;
    flagsT flagsNew;

    opBus opIf ();

    instrDecode uDecode (
        .firstLevelDecode  (firstLevelDecode),
        .specialEncoding   (specialEncoding),
        .secondLevelDecode (secondLevelDecode),
        .aluFunctions      (aluFunctions),
        .branchInstruction (branchInstruction),
        .imm               (imm),
        .destReg           (destReg),
        .sourceFirstReg    (sourceFirstReg),
        .sourceSecReg      (sourceSecReg),
        .readRegDest       (readRegDest),
        .readRegFirst      (readRegFirst),
        .readRegSec        (readRegSec),
        .op                (opIf)
    );

    aluExecute uExecute (
        .op            (opIf),
        .readDataDest  (readDataDest),
        .readDataFirst (readDataFirst),
        .readDataSec   (readDataSec),
        .result        (result),
        .flagsNew      (flagsNew)
    );

    writebackFlags uWriteback (
        .clk         (clk),
        .rst         (rst),
        .result      (result),
        .flagsNew    (flagsNew),
        .op          (opIf),
        .writeData   (writeData),
        .writeToReg  (writeToReg),
        .branchTaken (branchTaken),
        .flags       (flags)
    );

endmodule

//--- sim/tbModel.svh
// Expected outputs of one cycle, worked out from the instruction rules
typedef struct packed {
    wordT    writeData;
    logic    writeToReg;
    regAddrT regDest;
    regAddrT regFirst;
    regAddrT regSec;
    logic    branchTaken;
    flagsT   flagsNext;
} expectT;

function automatic expectT predictExecute(
    input logic [1:0] group,
    input logic       special,
    input logic [3:0] sec,
    input logic [2:0] fn,
    input logic [3:0] br,
    input immT        immV,
    input regAddrT    dReg,
    input regAddrT    fReg,
    input regAddrT    sReg,
    input wordT       dVal,
    input wordT       fVal,
    input wordT       sVal,
    input flagsT      fl
);
    expectT e;
    wordT   opB;
    wordT   res;
    longint wide;
    logic   known;
    logic   carry;
    logic   needFirst;
    e           = '0;
    e.flagsNext = fl;
    res         = '0;
    wide        = 0;
    carry       = 1'b0;
    known       = 1'b0;
    needFirst   = 1'b1;
    opB         = (group == 2'd0) ? {{16{immV[15]}}, immV} : sVal;
    if (group == 2'd1 || (group == 2'd0 && special)) begin
        known = (sec[2:0] >= 3'd1) && (sec[2:0] <= 3'd5);
        case (sec[2:0])
            3'd1: begin
                res   = fVal + opB;
                carry = res < fVal;   // Unsigned wrap around
                wide  = longint'($signed(fVal)) + longint'($signed(opB));
            end
            3'd2: begin
                res   = fVal - opB;
                carry = fVal >= opB;  // No borrow
                wide  = longint'($signed(fVal)) - longint'($signed(opB));
            end
            3'd3: res = fVal & opB;
            3'd4: res = fVal | opB;
            3'd5: res = fVal ^ opB;
            default: res = '0;
        endcase
        if (known && sec[3]) begin
            e.flagsNext[flagN] = res[31];
            e.flagsNext[flagZ] = (res == 0);
            if (sec[2:0] <= 3'd2) begin
                e.flagsNext[flagC] = carry;
                // Signed result that does not fit in 32 bits
                e.flagsNext[flagV] = (wide != longint'($signed(res)));
            end
        end
    end else if (group == 2'd0) begin
        known     = (fn <= 3'd5);
        needFirst = (fn >= 3'd4);   // Only the shifts read a source
        case (fn)
            3'd0: res = {{16{immV[15]}}, immV};
            3'd1: res = {immV, dVal[15:0]};
            3'd2: res = 32'h0000_0000;
            3'd3: res = 32'hffff_ffff;
            3'd4: res = (immV >= 16'd32) ? 32'h0 : fVal << immV[4:0];
            3'd5: res = (immV >= 16'd32) ? 32'h0 : fVal >> immV[4:0];
            default: res = '0;
        endcase
    end else if (group == 2'd3) begin
        case (br)
            4'd0: e.branchTaken = fl[flagZ];
            4'd1: e.branchTaken = !fl[flagZ];
            4'd4: e.branchTaken = fl[flagN];
            default: e.branchTaken = 1'b0;
        endcase
    end
    if (known) begin
        e.writeData  = res;
        e.writeToReg = 1'b1;
        e.regDest    = dReg;
        e.regFirst   = needFirst ? fReg : 4'd0;
        e.regSec     = (group == 2'd1) ? sReg : 4'd0;
    end
    return e;
endfunction

//--- sim/executeStageTb.sv
`timescale 1ns/100ps

module executeStageTb
    import isaPkg::*, datapathPkg::*;
();
    `include "tbModel.svh"

    localparam int resetCycles = 16;
    localparam int testCycles  = 4 + 200 + 200 + 17 + 11 + 13 + 6;  // Plus one per report
    localparam int cycleLimit  = 2 * testCycles + resetCycles;

    logic       clk;
    logic       rst;
    groupT      firstLevelDecode;
    logic       specialEncoding;
    logic [3:0] secondLevelDecode;
    logic [2:0] aluFunctions;
    logic [3:0] branchInstruction;
    immT        imm;
    regAddrT    destReg;
    regAddrT    sourceFirstReg;
    regAddrT    sourceSecReg;
    wordT       readDataDest;
    wordT       readDataFirst;
    wordT       readDataSec;
    regAddrT    readRegDest;
    regAddrT    readRegFirst;
    regAddrT    readRegSec;
    wordT       writeData;
    logic       writeToReg;
    logic       branchTaken;
    flagsT      flags;

    flagsT      modelFlags;
    expectT     expected;
    logic       checkOn;
    int         errCount;
    int         checkCount;
    int         errAtStart;
    int         checksAtStart;
    int         testsDone;
    int         cycleCount;
    string      testName;
    logic [3:0] secCodes [10] = '{secAdd, secSub, secAnd, secOr, secXor,
                                  secAdds, secSubs, secAnds, secOrs, secXors};

    executeStage u_dut (.*);

    always #5 clk = ~clk;

    task automatic reportMismatch(input string what, input wordT expV, input wordT actV);
        $display("MISMATCH %s %s expected %h actual %h", testName, what, expV, actV);
        errCount++;
    endtask

    // Compare every cycle once the inputs have settled
    always @(negedge clk) begin
        if (checkOn) begin
            expected = predictExecute(firstLevelDecode, specialEncoding, secondLevelDecode,
                aluFunctions, branchInstruction, imm, destReg, sourceFirstReg, sourceSecReg,
                readDataDest, readDataFirst, readDataSec, modelFlags);
            checkCount++;
            assert (writeData === expected.writeData)
                else reportMismatch("writeData", expected.writeData, writeData);
            assert (writeToReg === expected.writeToReg)
                else reportMismatch("writeToReg", 32'(expected.writeToReg), 32'(writeToReg));
            assert (readRegDest === expected.regDest)
                else reportMismatch("readRegDest", 32'(expected.regDest), 32'(readRegDest));
            assert (readRegFirst === expected.regFirst)
                else reportMismatch("readRegFirst", 32'(expected.regFirst), 32'(readRegFirst));
            assert (readRegSec === expected.regSec)
                else reportMismatch("readRegSec", 32'(expected.regSec), 32'(readRegSec));
            assert (branchTaken === expected.branchTaken)
                else reportMismatch("branchTaken", 32'(expected.branchTaken), 32'(branchTaken));
            assert (flags === modelFlags)
                else reportMismatch("flags", 32'(modelFlags), 32'(flags));
            modelFlags = expected.flagsNext;   // Register loads at the next edge
        end
    end

    task automatic driveOp(input groupT g, input logic sp, input logic [3:0] sec,
                           input logic [2:0] fn, input logic [3:0] br, input immT iv,
                           input wordT dv, input wordT fv, input wordT sv);
        @(posedge clk);
        firstLevelDecode  <= g;
        specialEncoding   <= sp;
        secondLevelDecode <= sec;
        aluFunctions      <= fn;
        branchInstruction <= br;
        imm               <= iv;
        destReg           <= 4'($urandom);
        sourceFirstReg    <= 4'($urandom);
        sourceSecReg      <= 4'($urandom);
        readDataDest      <= dv;
        readDataFirst     <= fv;
        readDataSec       <= sv;
    endtask

    task automatic randomOp(input groupT g);
        wordT fv;
        wordT sv;
        fv = $urandom;
        sv = $urandom;
        if ($urandom % 8 == 0) sv = fv;   // Equal operands reach Z
        driveOp(g, g == groupImm, secCodes[4'($urandom % 10)], 3'($urandom), 4'($urandom),
                16'($urandom), $urandom, fv, sv);
    endtask

    task automatic branchTriple();
        driveOp(groupBranch, 1'b0, 4'd0, 3'd0, brEq, '0, '0, '0, '0);
        driveOp(groupBranch, 1'b0, 4'd0, 3'd0, brNe, '0, '0, '0, '0);
        driveOp(groupBranch, 1'b0, 4'd0, 3'd0, brMi, '0, '0, '0, '0);
    endtask

    task automatic startTest(input string name);
        testName      = name;
        errAtStart    = errCount;
        checksAtStart = checkCount;
    endtask

    task automatic finishTest();
        @(negedge clk);
        #1;
        testsDone++;
        $display("%-12s %0d checks, %0d errors", testName,
                 checkCount - checksAtStart, errCount - errAtStart);
    endtask

    initial begin
        cycleCount = 0;
        while (cycleCount < cycleLimit) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("Timeout after %0d cycles, the tests did not finish", cycleLimit);
        $display("Test failed");
        $finish;
    end

    initial begin
        clk               = 1'b0;
        rst               = 1'b1;
        firstLevelDecode  = groupMem;   // Decodes as no operation
        specialEncoding   = 1'b0;
        secondLevelDecode = '0;
        aluFunctions      = '0;
        branchInstruction = '0;
        imm               = '0;
        destReg           = '0;
        sourceFirstReg    = '0;
        sourceSecReg      = '0;
        readDataDest      = '0;
        readDataFirst     = '0;
        readDataSec       = '0;
        modelFlags        = '0;
        checkOn           = 1'b0;
        errCount          = 0;
        checkCount        = 0;
        testsDone         = 0;
        void'($urandom(39));

        startTest("resetFlags");
        repeat (resetCycles) @(posedge clk);
        rst     <= 1'b0;
        checkOn <= 1'b1;
        @(negedge clk);
        assert (flags === 4'b0000)
            else reportMismatch("flags", 32'h0, 32'(flags));
        branchTriple();
        finishTest();

        startTest("randomImm");
        repeat (200) randomOp(groupImm);
        finishTest();

        startTest("randomReg");
        repeat (200) randomOp(groupReg);
        finishTest();

        startTest("flagCases");
        driveOp(groupImm, 1'b1, secAdds, 3'd0, 4'd0, 16'h0001, '0, 32'h7fff_ffff, '0);
        branchTriple();
        driveOp(groupReg, 1'b0, secSubs, 3'd0, 4'd0, '0, '0, 32'h1234_5678, 32'h1234_5678);
        branchTriple();
        driveOp(groupReg, 1'b0, secSubs, 3'd0, 4'd0, '0, '0, 32'd5, 32'd9);   // Borrow
        branchTriple();
        // Carry and overflow set first so ANDS has C and V to keep
        driveOp(groupReg, 1'b0, secAdds, 3'd0, 4'd0, '0, '0, 32'h8000_0000, 32'h8000_0000);
        driveOp(groupReg, 1'b0, secAnds, 3'd0, 4'd0, '0, '0, 32'hf000_0000, 32'hffff_0000);
        branchTriple();
        finishTest();

        startTest("moveGroup");
        driveOp(groupImm, 1'b0, 4'd0, fnMov, 4'd0, 16'h8001, '0, '0, '0);
        driveOp(groupImm, 1'b0, 4'd0, fnMov, 4'd0, 16'h1234, '0, '0, '0);
        driveOp(groupImm, 1'b0, 4'd0, fnMovt, 4'd0, 16'habcd, 32'h1111_2222, '0, '0);
        driveOp(groupImm, 1'b0, 4'd0, fnClr, 4'd0, 16'h5555, '0, '0, '0);
        driveOp(groupImm, 1'b0, 4'd0, fnSet, 4'd0, 16'h0000, '0, '0, '0);
        driveOp(groupImm, 1'b0, 4'd0, fnLsl, 4'd0, 16'd0, '0, 32'hdead_beef, '0);
        driveOp(groupImm, 1'b0, 4'd0, fnLsl, 4'd0, 16'd31, '0, 32'hdead_beef, '0);
        driveOp(groupImm, 1'b0, 4'd0, fnLsl, 4'd0, 16'd40, '0, 32'hdead_beef, '0);
        driveOp(groupImm, 1'b0, 4'd0, fnLsr, 4'd0, 16'd0, '0, 32'h8000_0001, '0);
        driveOp(groupImm, 1'b0, 4'd0, fnLsr, 4'd0, 16'd31, '0, 32'h8000_0001, '0);
        driveOp(groupImm, 1'b0, 4'd0, fnLsr, 4'd0, 16'd40, '0, 32'h8000_0001, '0);
        finishTest();

        startTest("noOps");
        driveOp(groupReg, 1'b0, secSubs, 3'd0, 4'd0, '0, '0, 32'd5, 32'd9);   // Leaves N set and C clear
        repeat (3) randomOp(groupMem);
        driveOp(groupImm, 1'b0, 4'd0, 3'd6, 4'd0, 16'h00ff, '0, 32'h1, '0);
        driveOp(groupImm, 1'b0, 4'd0, 3'd7, 4'd0, 16'h00ff, '0, 32'h1, '0);
        driveOp(groupImm, 1'b1, 4'd0, 3'd0, 4'd0, 16'h0001, '0, 32'h0, '0);
        driveOp(groupImm, 1'b1, 4'd6, 3'd0, 4'd0, 16'h0001, '0, 32'h0, '0);
        driveOp(groupImm, 1'b1, 4'd15, 3'd0, 4'd0, 16'h0001, '0, 32'h0, '0);
        driveOp(groupReg, 1'b0, 4'd7, 3'd0, 4'd0, '0, '0, 32'h0, 32'h0);
        driveOp(groupReg, 1'b0, 4'd8, 3'd0, 4'd0, '0, '0, 32'h0, 32'h0);
        driveOp(groupBranch, 1'b0, 4'd0, 3'd0, 4'd2, '0, '0, '0, '0);
        driveOp(groupBranch, 1'b0, 4'd0, 3'd0, brMi, '0, '0, '0, '0);
        finishTest();

        $display("Tests %0d, checks %0d, errors %0d", testsDone, checkCount, errCount);
        if (errCount == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- build.f
+incdir+sim
source/isaPkg.sv
source/datapathPkg.sv
source/opBus.sv
source/instrDecode.sv
source/aluExecute.sv
source/writebackFlags.sv
source/executeStage.sv
sim/executeStageTb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f build.f --top-module executeStageTb \
        -o simExecuteStage; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/simExecuteStage 2>&1)
status=$?
echo "$output"

if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "Test completed successfully" <<< "$output"; then
    exit 0
fi
exit 1
